// File: include/int_div_params.svh
/*
  width settings for the iterative divider
  the counter must hold XLEN-1, so CNT_W is at least clog2(XLEN)
*/

`ifndef INT_DIV_PARAMS_SVH
`define INT_DIV_PARAMS_SVH

// operand, quotient and remainder width
`define INT_DIV_XLEN 32
// iteration counter width, counts XLEN-1 down to 0
`define INT_DIV_CNT_W 5

`endif

// File: logic/int_div_pkg.sv
/*
  shared types for the divider
  widths come from the params header
*/

`default_nettype none

`include "int_div_params.svh"

package int_div_pkg;

  // --------------------------------------------------
  // data widths
  // --------------------------------------------------

  // one operand or result word
  typedef logic [`INT_DIV_XLEN-1:0] xlen_t;

  // working register, partial remainder on top and quotient bits below
  // one extra bit keeps the sign of the trial subtraction
  typedef logic [2*`INT_DIV_XLEN:0] acc_t;

  // step counter
  typedef logic [`INT_DIV_CNT_W-1:0] cnt_t;

  // --------------------------------------------------
  // function code
  // --------------------------------------------------
  typedef logic div_fn_t;

  localparam div_fn_t DIV_FN_UNSIGNED = 1'b0;
  localparam div_fn_t DIV_FN_SIGNED   = 1'b1;

  // control FSM states
  typedef enum logic [1:0] {IDLE, CALC, DONE} div_state_e;

endpackage

`default_nettype wire

// File: logic/int_div_ctrl_if.sv
/*
  step control between the divider FSM and its datapath
  no clock here, both sides sample on their own clk
*/

`timescale 1ns/1ns
`default_nettype none

interface int_div_ctrl_if;

  // ctrl to dpath
  logic load;     // capture operands, sign flags and counter start
  logic step;     // one shift-subtract, counter decrements
  logic restore;  // keep shifted value, quotient bit zero

  // dpath to ctrl
  logic sub_neg;    // trial subtraction went negative
  logic last_step;  // counter reached zero

  modport ctrl (
    output load, step, restore,
    input  sub_neg, last_step
  );

  modport dpath (
    input  load, step, restore,
    output sub_neg, last_step
  );

endinterface

`default_nettype wire

// File: logic/int_div_dpath.sv
/*
  restoring divider datapath, one quotient bit per step on magnitudes
  divide by zero and signed overflow fall out of the algorithm with no special case
*/

`timescale 1ns/1ns
`default_nettype none

module int_div_dpath (
  input  logic                  clk,
  input  logic                  reset,
  input  int_div_pkg::div_fn_t  req_fn,
  input  int_div_pkg::xlen_t    req_a,
  input  int_div_pkg::xlen_t    req_b,
  output int_div_pkg::xlen_t    resp_quot,
  output int_div_pkg::xlen_t    resp_rem,
  int_div_ctrl_if.dpath         dp
);

  localparam int XLEN = $bits(int_div_pkg::xlen_t);

  // --------------------------------------------------
  // operand magnitudes
  // --------------------------------------------------
  logic               is_signed;
  logic               a_neg;
  logic               b_neg;
  int_div_pkg::xlen_t a_mag;
  int_div_pkg::xlen_t b_mag;

  assign is_signed = (req_fn == int_div_pkg::DIV_FN_SIGNED);

  // sign bits only count for signed requests
  assign a_neg = is_signed & req_a[XLEN-1];
  assign b_neg = is_signed & req_b[XLEN-1];

  // two's complement negate when negative
  // -2^31 maps to itself, read as unsigned 2^31
  assign a_mag = a_neg ? (~req_a + 1'b1) : req_a;
  assign b_mag = b_neg ? (~req_b + 1'b1) : req_b;

  // --------------------------------------------------
  // working registers
  // --------------------------------------------------
  int_div_pkg::acc_t acc;
  int_div_pkg::acc_t dvsr;
  int_div_pkg::cnt_t cnt;
  logic              quot_neg;
  logic              rem_neg;

  int_div_pkg::acc_t acc_shift;
  int_div_pkg::acc_t acc_diff;
  int_div_pkg::acc_t acc_next;

  // shift first, then trial subtract of the divisor from the upper half
  assign acc_shift = acc << 1;
  assign acc_diff  = acc_shift - dvsr;

  // top bit set means the partial remainder was smaller than the divisor
  assign dp.sub_neg = acc_diff[2*XLEN];

  // restore keeps the shifted value and shifts in a zero quotient bit
  assign acc_next = dp.restore ? {acc_shift[2*XLEN:1], 1'b0}
                               : {acc_diff[2*XLEN:1], 1'b1};

  assign dp.last_step = (cnt == '0);

  // payload, written only on load or step
  always_ff @(posedge clk) begin
    if (dp.load) begin
      acc  <= {{(XLEN+1){1'b0}}, a_mag};
      dvsr <= {1'b0, b_mag, {XLEN{1'b0}}};
    end else if (dp.step) begin
      acc <= acc_next;
    end
  end

  // counter and sign flags
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt      <= '0;
      quot_neg <= 1'b0;
      rem_neg  <= 1'b0;
    end else if (dp.load) begin
      cnt      <= int_div_pkg::cnt_t'(XLEN - 1);
      // quotient negative when operand signs differ
      quot_neg <= a_neg ^ b_neg;
      // remainder takes the dividend sign
      rem_neg  <= a_neg;
    end else if (dp.step) begin
      cnt <= cnt - 1'b1;
    end
  end

  // --------------------------------------------------
  // sign fix-up of results
  // --------------------------------------------------
  int_div_pkg::xlen_t quot_mag;
  int_div_pkg::xlen_t rem_mag;

  assign quot_mag = acc[XLEN-1:0];
  assign rem_mag  = acc[2*XLEN-1:XLEN];

  // valid whenever the FSM sits in DONE
  assign resp_quot = quot_neg ? (~quot_mag + 1'b1) : quot_mag;
  assign resp_rem  = rem_neg ? (~rem_mag + 1'b1) : rem_mag;

endmodule

`default_nettype wire

// File: logic/int_div_ctrl.sv
/*
  divider control FSM, one operation in flight
  all outputs are combinational from state and inputs
*/

`timescale 1ns/1ns
`default_nettype none

module int_div_ctrl (
  input  logic          clk,
  input  logic          reset,
  input  logic          req_val,
  output logic          req_rdy,
  output logic          resp_val,
  input  logic          resp_rdy,
  int_div_ctrl_if.ctrl  ctl
);

  int_div_pkg::div_state_e state;
  int_div_pkg::div_state_e state_next;

  // handshake transfers
  logic req_go;
  logic resp_go;

  assign req_go  = req_val & req_rdy;
  assign resp_go = resp_val & resp_rdy;

  // --------------------------------------------------
  // state register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= int_div_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      // wait for a request
      int_div_pkg::IDLE: begin
        if (req_go) begin
          state_next = int_div_pkg::CALC;
        end
      end
      // the step taken at counter zero is the last one
      int_div_pkg::CALC: begin
        if (ctl.last_step) begin
          state_next = int_div_pkg::DONE;
        end
      end
      // hold results until the consumer takes them
      int_div_pkg::DONE: begin
        if (resp_go) begin
          state_next = int_div_pkg::IDLE;
        end
      end
      default: begin
        state_next = int_div_pkg::IDLE;
      end
    endcase
  end

  // --------------------------------------------------
  // outputs
  // --------------------------------------------------
  assign req_rdy  = (state == int_div_pkg::IDLE);
  assign resp_val = (state == int_div_pkg::DONE);

  // operands captured on the accept edge
  assign ctl.load = (state == int_div_pkg::IDLE) & req_val;

  // step every CALC cycle, restore follows the trial subtraction
  assign ctl.step    = (state == int_div_pkg::CALC);
  assign ctl.restore = (state == int_div_pkg::CALC) & ctl.sub_neg;

endmodule

`default_nettype wire

// File: logic/int_div_unit.sv
/*
  iterative 32-bit divider, valid/ready in and out, no pipelining
  requester holds fn and operands while req_val waits on req_rdy
*/

`timescale 1ns/1ns
`default_nettype none

module int_div_unit (
  input  logic                  clk,
  input  logic                  reset,

  // request side
  input  logic                  req_val,
  output logic                  req_rdy,
  input  int_div_pkg::div_fn_t  req_fn,
  input  int_div_pkg::xlen_t    req_a,
  input  int_div_pkg::xlen_t    req_b,

  // response side
  output logic                  resp_val,
  input  logic                  resp_rdy,
  output int_div_pkg::xlen_t    resp_quot,
  output int_div_pkg::xlen_t    resp_rem
);

  // --------------------------------------------------
  // control to datapath link
  // --------------------------------------------------
  int_div_ctrl_if ctl_if ();

  // FSM owns both handshakes
  int_div_ctrl ctrl_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .ctl      (ctl_if.ctrl)
  );

  // sign decisions live only in the datapath
  int_div_dpath dpath_i (
    .clk       (clk),
    .reset     (reset),
    .req_fn    (req_fn),
    .req_a     (req_a),
    .req_b     (req_b),
    .resp_quot (resp_quot),
    .resp_rem  (resp_rem),
    .dp        (ctl_if.dpath)
  );

endmodule

`default_nettype wire

// File: testbench/int_div_tb.sv
/*
  random self-checking testbench for int_div_unit with a fixed seed of 82238
  expected results come from a magnitude-division model with the div-by-zero and overflow rules
*/

`timescale 1ns/1ns
`default_nettype none

`include "int_div_params.svh"

module int_div_tb;

  localparam int XLEN        = `INT_DIV_XLEN;
  // edges up to resp_val with the accept edge counted as the first
  localparam int RESP_EDGES  = 33;
  localparam int MAX_STALL   = 8;
  localparam int N_RAND      = 200;
  localparam int N_CORNER    = 10;
  localparam int N_STALL     = 50;
  localparam int N_OPS       = 2 * N_RAND + N_CORNER + N_STALL;
  // per op the latency plus the longest stall and a few handshake cycles
  localparam int WATCHDOG_NS = N_OPS * (33 + MAX_STALL + 4) * 10 + 2000;
  localparam int WAIT_LIMIT  = 64;

  logic                 clk;
  logic                 reset;
  logic                 req_val;
  logic                 req_rdy;
  int_div_pkg::div_fn_t req_fn;
  int_div_pkg::xlen_t   req_a;
  int_div_pkg::xlen_t   req_b;
  logic                 resp_val;
  logic                 resp_rdy;
  int_div_pkg::xlen_t   resp_quot;
  int_div_pkg::xlen_t   resp_rem;

  integer seed = 82238;
  int     errors;
  int     tests_passed;
  int     tests_failed;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  int_div_unit dut_i (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .req_fn    (req_fn),
    .req_a     (req_a),
    .req_b     (req_b),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .resp_quot (resp_quot),
    .resp_rem  (resp_rem)
  );

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  // inputs change and outputs are read 1 ns after the edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $finish;
  endtask

  // watchdog for a unit that stops answering
  initial begin
    #(WATCHDOG_NS);
    abort_run($sformatf("timeout: the run did not finish within %0d ns", WATCHDOG_NS));
  end

  // expected quotient and remainder
  task automatic ref_div(input int_div_pkg::div_fn_t fn, input int_div_pkg::xlen_t a,
                         input int_div_pkg::xlen_t b, output int_div_pkg::xlen_t q,
                         output int_div_pkg::xlen_t r);
    int_div_pkg::xlen_t ma;
    int_div_pkg::xlen_t mb;
    logic               neg_a;
    logic               neg_b;
    neg_a = (fn == int_div_pkg::DIV_FN_SIGNED) && a[XLEN-1];
    neg_b = (fn == int_div_pkg::DIV_FN_SIGNED) && b[XLEN-1];
    ma = neg_a ? -a : a;
    mb = neg_b ? -b : b;
    if (b == '0) begin
      // divide by zero gives all ones or 1 for a negative signed dividend
      q = neg_a ? int_div_pkg::xlen_t'(1) : '1;
      r = a;
    end else if (neg_a && neg_b && a == {1'b1, {(XLEN-1){1'b0}}} && b == '1) begin
      // signed overflow wraps back to the dividend
      q = a;
      r = '0;
    end else begin
      q = ma / mb;
      r = ma % mb;
      // quotient sign from both operands, remainder sign from the dividend
      if (neg_a ^ neg_b) q = -q;
      if (neg_a) r = -r;
    end
  endtask

  // random word shifted right by a random amount to spread the magnitudes
  task automatic rand_operand(input logic signed_op, output int_div_pkg::xlen_t v);
    int_div_pkg::xlen_t mag;
    mag = $random(seed);
    mag = mag >> ($unsigned($random(seed)) % XLEN);
    if (signed_op && ($random(seed) % 2 != 0)) begin
      v = -mag;
    end else begin
      v = mag;
    end
  endtask

  // one request and its response after stall cycles of back-pressure
  task automatic run_op(input int_div_pkg::div_fn_t fn, input int_div_pkg::xlen_t a,
                        input int_div_pkg::xlen_t b, input int stall);
    int_div_pkg::xlen_t exp_q;
    int_div_pkg::xlen_t exp_r;
    int_div_pkg::xlen_t held_q;
    int_div_pkg::xlen_t held_r;
    int                 edges;
    int                 waited;
    ref_div(fn, a, b, exp_q, exp_r);
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    waited  = 0;
    while (!req_rdy && waited < WAIT_LIMIT) begin
      tick();
      waited++;
    end
    if (!req_rdy) begin
      $display("request was never accepted, req_rdy stayed low up to %0t", $time);
      req_val = 1'b0;
      errors++;
      return;
    end
    // accept edge
    tick();
    req_val = 1'b0;
    edges   = 1;
    // count edges until the result shows up
    while (!resp_val && edges < WAIT_LIMIT) begin
      if (req_rdy) begin
        $display("** Error at %0t: req_rdy rose while the divide was still running", $time);
        errors++;
      end
      tick();
      edges++;
    end
    if (!resp_val) begin
      $display("no response, resp_val never rose after the request up to %0t", $time);
      errors++;
      return;
    end
    if (edges != RESP_EDGES) begin
      $display("** Error at %0t: resp_val after %0d edges, expected %0d",
               $time, edges, RESP_EDGES);
      errors++;
    end
    if (resp_quot !== exp_q || resp_rem !== exp_r) begin
      $display("** Error at %0t: fn=%0d a=%h b=%h got q=%h r=%h, expected q=%h r=%h",
               $time, fn, a, b, resp_quot, resp_rem, exp_q, exp_r);
      errors++;
    end
    // results must sit still while the consumer stalls
    held_q = resp_quot;
    held_r = resp_rem;
    repeat (stall) begin
      tick();
      if (!resp_val || req_rdy) begin
        $display("** Error at %0t: handshake changed while the response was waiting", $time);
        errors++;
      end
      if (resp_quot !== held_q || resp_rem !== held_r) begin
        $display("** Error at %0t: result moved under back-pressure, q=%h r=%h was q=%h r=%h",
                 $time, resp_quot, resp_rem, held_q, held_r);
        errors++;
      end
    end
    resp_rdy = 1'b1;
    tick();
    resp_rdy = 1'b0;
    if (resp_val || !req_rdy) begin
      $display("** Error at %0t: unit did not return to idle after the response transfer",
               $time);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - errs_before);
    end
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    int                   errs_before;
    int                   i;
    int                   gap;
    int_div_pkg::xlen_t   a;
    int_div_pkg::xlen_t   b;
    int_div_pkg::div_fn_t fn;
    reset        = 1'b1;
    req_val      = 1'b0;
    req_fn       = int_div_pkg::DIV_FN_UNSIGNED;
    req_a        = '0;
    req_b        = '0;
    resp_rdy     = 1'b0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    // idle handshake state straight out of reset
    errs_before = errors;
    if (req_rdy !== 1'b1 || resp_val !== 1'b0) begin
      $display("** Error at %0t: after reset req_rdy=%b resp_val=%b, expected 1 and 0",
               $time, req_rdy, resp_val);
      errors++;
    end
    end_test("test 1 reset state", errs_before);

    // unsigned with random idle gaps between requests
    errs_before = errors;
    for (i = 0; i < N_RAND; i++) begin
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) tick();
      rand_operand(1'b0, a);
      rand_operand(1'b0, b);
      run_op(int_div_pkg::DIV_FN_UNSIGNED, a, b, 0);
    end
    end_test("test 2 random unsigned", errs_before);

    // signed with each operand negative about half the time
    errs_before = errors;
    for (i = 0; i < N_RAND; i++) begin
      rand_operand(1'b1, a);
      rand_operand(1'b1, b);
      run_op(int_div_pkg::DIV_FN_SIGNED, a, b, 0);
    end
    end_test("test 3 random signed", errs_before);

    // corner operands for both functions
    errs_before = errors;
    for (i = 0; i < 2; i++) begin
      fn = int_div_pkg::div_fn_t'(i);
      run_op(fn, 32'h8000_0005, 32'h0000_0000, 0);
      run_op(fn, 32'h0000_0007, 32'h0000_0000, 0);
      run_op(fn, 32'hdead_beef, 32'h0000_0001, 0);
      run_op(fn, 32'h8000_0000, 32'hffff_ffff, 0);
      run_op(fn, 32'h0000_0005, 32'h0000_1234, 0);
    end
    end_test("test 4 corner operands", errs_before);

    // back-pressure of 0 to 8 cycles on the response
    errs_before = errors;
    for (i = 0; i < N_STALL; i++) begin
      if ($random(seed) % 2 != 0) begin
        fn = int_div_pkg::DIV_FN_SIGNED;
      end else begin
        fn = int_div_pkg::DIV_FN_UNSIGNED;
      end
      rand_operand(fn, a);
      rand_operand(fn, b);
      run_op(fn, a, b, $unsigned($random(seed)) % (MAX_STALL + 1));
    end
    end_test("test 5 response back-pressure", errs_before);

    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
logic/int_div_pkg.sv
logic/int_div_ctrl_if.sv
logic/int_div_dpath.sv
logic/int_div_ctrl.sv
logic/int_div_unit.sv
testbench/int_div_tb.sv

// File: Bender.yml
package:
  name: int_div

export_include_dirs:
  - include

sources:
  # divider RTL in compile order
  - include_dirs:
      - include
    files:
      - logic/int_div_pkg.sv
      - logic/int_div_ctrl_if.sv
      - logic/int_div_dpath.sv
      - logic/int_div_ctrl.sv
      - logic/int_div_unit.sv

  # self-checking testbench
  - target: test
    include_dirs:
      - include
    files:
      - testbench/int_div_tb.sv
